// File: hdl/barrel_pkg.sv
package barrel_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  // word address into the instruction rom, pc[11:2]
  typedef logic [9:0] rom_addr_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // ------------------------------------------------------------------------
  // opcodes and funct3 codes
  // ------------------------------------------------------------------------
  localparam opcode_t OPC_OP = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI = 7'b0110111;
  localparam opcode_t OPC_JAL = 7'b1101111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  // alu group
  localparam funct3_t F3_ADD = 3'd0;
  localparam funct3_t F3_SLL = 3'd1;
  localparam funct3_t F3_SLT = 3'd2;
  localparam funct3_t F3_SLTU = 3'd3;
  localparam funct3_t F3_XOR = 3'd4;
  localparam funct3_t F3_SR = 3'd5;
  localparam funct3_t F3_OR = 3'd6;
  localparam funct3_t F3_AND = 3'd7;

  // branch group
  localparam funct3_t F3_BEQ = 3'd0;
  localparam funct3_t F3_BNE = 3'd1;
  localparam funct3_t F3_BLT = 3'd4;
  localparam funct3_t F3_BGE = 3'd5;
  localparam funct3_t F3_BLTU = 3'd6;
  localparam funct3_t F3_BGEU = 3'd7;

  // funct7 bit picking sub and sra
  localparam int ALT_BIT = 30;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // holds the hart number after reset
  localparam reg_addr_t HART_REG = 5'd10;
  // pipeline depth, one thread per stage
  localparam int MIN_THREADS = 4;

endpackage

// File: hdl/barrel_ifs.sv
`timescale 1ns/100ps

// writeback broadcast from the scheduler to all contexts
interface ctx_write_if #(
  parameter int NUM_THREADS = 4
);
  import barrel_pkg::*;

  localparam int TW = $clog2(NUM_THREADS);

  logic rd_we;
  logic [TW-1:0] thread;
  reg_addr_t rd;
  word_t data;
  logic pc_we;
  word_t next_pc;

  modport sched (
    output rd_we, thread, rd, data, pc_we, next_pc
  );

  modport ctx (
    input rd_we, thread, rd, data, pc_we, next_pc
  );

endinterface

// per-context view of pc and operands
interface ctx_read_if;
  import barrel_pkg::*;

  word_t pc;
  word_t rs1_data;
  word_t rs2_data;

  modport ctx (
    output pc, rs1_data, rs2_data
  );

  modport sel (
    input pc, rs1_data, rs2_data
  );

endinterface

// File: hdl/thread_scheduler.sv
`timescale 1ns/100ps

module thread_scheduler #(
  parameter int NUM_THREADS = 4
) (
  input logic clk,
  input logic reset,
  input logic i_wb_valid,
  input barrel_pkg::reg_addr_t i_wb_rd,
  input logic i_wb_rd_we,
  input barrel_pkg::word_t i_wb_data,
  input barrel_pkg::word_t i_wb_next_pc,
  output logic [$clog2(NUM_THREADS)-1:0] o_fetch_thread,
  output logic [$clog2(NUM_THREADS)-1:0] o_decode_thread,
  output logic o_fetch_valid,
  output logic [$clog2(NUM_THREADS)-1:0] o_wb_thread,
  ctx_write_if.sched wr
);

  localparam int TW = $clog2(NUM_THREADS);
  typedef logic [TW-1:0] thread_t;

  logic start;
  logic start_reg;
  thread_t fetch_tag;
  thread_t decode_tag;
  thread_t ex_tag;
  thread_t wb_tag;

  // ------------------------------------------------------------------------
  // start delay and round robin
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
      start_reg <= 1'b0;
      fetch_tag <= '0;
      decode_tag <= '0;
      ex_tag <= '0;
      wb_tag <= '0;
    end else begin
      start <= 1'b1;
      start_reg <= start;
      if (start_reg) begin
        fetch_tag <= (fetch_tag == thread_t'(NUM_THREADS - 1)) ? '0 : fetch_tag + 1'b1;
      end
      decode_tag <= fetch_tag;
      ex_tag <= decode_tag;
      wb_tag <= ex_tag;
    end
  end

  assign o_fetch_valid = start_reg;
  assign o_fetch_thread = fetch_tag;
  assign o_decode_thread = decode_tag;
  assign o_wb_thread = wb_tag;

  // ------------------------------------------------------------------------
  // writeback broadcast
  // ------------------------------------------------------------------------
  // no register write for rd == 0
  assign wr.rd_we = i_wb_valid & i_wb_rd_we & (i_wb_rd != '0);
  assign wr.thread = wb_tag;
  assign wr.rd = i_wb_rd;
  assign wr.data = i_wb_data;
  assign wr.pc_we = i_wb_valid;
  assign wr.next_pc = i_wb_next_pc;

  a_fetch_step: assert property (@(posedge clk) disable iff (reset)
    start_reg |=> fetch_tag == (($past(fetch_tag) == thread_t'(NUM_THREADS - 1)) ?
                                thread_t'(0) : thread_t'($past(fetch_tag) + 1'b1)));

endmodule

// File: hdl/thread_context.sv
`timescale 1ns/100ps

module thread_context #(
  parameter int NUM_THREADS = 4,
  parameter int THREAD_ID = 0
) (
  input logic clk,
  input logic reset,
  input barrel_pkg::reg_addr_t i_rs1,
  input barrel_pkg::reg_addr_t i_rs2,
  ctx_write_if.ctx wr,
  ctx_read_if.ctx rd
);

  import barrel_pkg::*;

  localparam int TW = $clog2(NUM_THREADS);

  word_t pc;
  word_t regs [32];
  logic mine;

  // broadcast is for this thread
  assign mine = (wr.thread == TW'(THREAD_ID));

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (wr.pc_we && mine) begin
      pc <= wr.next_pc;
    end
  end

  // x10 comes up as the hart number
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= (reg_addr_t'(i) == HART_REG) ? word_t'(THREAD_ID) : '0;
      end
    end else if (wr.rd_we && mine) begin
      regs[wr.rd] <= wr.data;
    end
  end

  assign rd.pc = pc;
  assign rd.rs1_data = regs[i_rs1];
  assign rd.rs2_data = regs[i_rs2];

  // relies on the scheduler never enabling a write to x0
  a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

// File: hdl/context_select.sv
`timescale 1ns/100ps

module context_select #(
  parameter int NUM_THREADS = 4
) (
  input logic [$clog2(NUM_THREADS)-1:0] i_fetch_thread,
  input logic [$clog2(NUM_THREADS)-1:0] i_decode_thread,
  ctx_read_if.sel rd [NUM_THREADS],
  output barrel_pkg::word_t o_fetch_pc,
  output barrel_pkg::word_t o_rs1_data,
  output barrel_pkg::word_t o_rs2_data
);

  import barrel_pkg::*;

  word_t pc_arr [NUM_THREADS];
  word_t rs1_arr [NUM_THREADS];
  word_t rs2_arr [NUM_THREADS];

  // interface arrays only take constant indices
  for (genvar g = 0; g < NUM_THREADS; g++) begin : g_drain
    assign pc_arr[g] = rd[g].pc;
    assign rs1_arr[g] = rd[g].rs1_data;
    assign rs2_arr[g] = rd[g].rs2_data;
  end

  // fetch side pc
  assign o_fetch_pc = pc_arr[i_fetch_thread];

  // decode side operands
  assign o_rs1_data = rs1_arr[i_decode_thread];
  assign o_rs2_data = rs2_arr[i_decode_thread];

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/100ps

module decode_unit (
  input logic clk,
  input logic reset,
  input barrel_pkg::word_t i_instruction,
  input logic i_valid,
  input barrel_pkg::word_t i_fetch_pc,
  input barrel_pkg::word_t i_rs1_data,
  input barrel_pkg::word_t i_rs2_data,
  output barrel_pkg::reg_addr_t o_rs1,
  output barrel_pkg::reg_addr_t o_rs2,
  output logic o_ex_valid,
  output barrel_pkg::alu_op_e o_ex_alu_op,
  output barrel_pkg::word_t o_ex_op1,
  output barrel_pkg::word_t o_ex_op2,
  output barrel_pkg::word_t o_ex_pc,
  output barrel_pkg::word_t o_ex_imm,
  output barrel_pkg::reg_addr_t o_ex_rd,
  output logic o_ex_rd_we,
  output logic o_ex_is_branch,
  output logic o_ex_is_jump,
  output barrel_pkg::funct3_t o_ex_funct3
);

  import barrel_pkg::*;

  function automatic alu_op_e alu_decode(input funct3_t f3, input logic alt);
    case (f3)
      F3_ADD: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL: return ALU_SLL;
      F3_SLT: return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR: return ALU_XOR;
      F3_SR: return alt ? ALU_SRA : ALU_SRL;
      F3_OR: return ALU_OR;
      F3_AND: return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  word_t pc_d;
  logic valid_d;
  opcode_t opcode;
  funct3_t funct3;
  word_t imm_i, imm_u, imm_b, imm_j;
  alu_op_e alu_op;
  word_t op1, op2, imm;
  logic rd_we, is_branch, is_jump;

  // fetch stage register, pc waits for the rom word
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= i_valid;
    end
    pc_d <= i_fetch_pc;
  end

  // ------------------------------------------------------------------------
  // fields and immediates
  // ------------------------------------------------------------------------
  assign opcode = i_instruction[6:0];
  assign funct3 = i_instruction[14:12];
  assign o_rs1 = i_instruction[19:15];
  assign o_rs2 = i_instruction[24:20];

  assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};
  assign imm_u = {i_instruction[31:12], 12'b0};
  assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                  i_instruction[30:25], i_instruction[11:8], 1'b0};
  assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
                  i_instruction[20], i_instruction[30:21], 1'b0};

  // unknown opcodes fall through as a nop
  always_comb begin
    alu_op = ALU_ADD;
    op1 = i_rs1_data;
    op2 = i_rs2_data;
    imm = imm_i;
    rd_we = 1'b0;
    is_branch = 1'b0;
    is_jump = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op = alu_decode(funct3, i_instruction[ALT_BIT]);
        rd_we = 1'b1;
      end
      OPC_OP_IMM: begin
        // only the shifts use the alt bit here, addi has no subi
        alu_op = alu_decode(funct3, (funct3 == F3_SR) & i_instruction[ALT_BIT]);
        op2 = imm_i;
        rd_we = 1'b1;
      end
      OPC_LUI: begin
        op1 = '0;
        op2 = imm_u;
        imm = imm_u;
        rd_we = 1'b1;
      end
      OPC_JAL: begin
        imm = imm_j;
        rd_we = 1'b1;
        is_jump = 1'b1;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        is_branch = 1'b1;
      end
      default: ;
    endcase
  end

  // decode/execute register
  always_ff @(posedge clk) begin
    if (reset) begin
      o_ex_valid <= 1'b0;
    end else begin
      o_ex_valid <= valid_d;
    end
    o_ex_alu_op <= alu_op;
    o_ex_op1 <= op1;
    o_ex_op2 <= op2;
    o_ex_pc <= pc_d;
    o_ex_imm <= imm;
    o_ex_rd <= i_instruction[11:7];
    o_ex_rd_we <= rd_we;
    o_ex_is_branch <= is_branch;
    o_ex_is_jump <= is_jump;
    o_ex_funct3 <= funct3;
  end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
  input logic clk,
  input logic reset,
  input logic i_ex_valid,
  input barrel_pkg::alu_op_e i_ex_alu_op,
  input barrel_pkg::word_t i_ex_op1,
  input barrel_pkg::word_t i_ex_op2,
  input barrel_pkg::word_t i_ex_pc,
  input barrel_pkg::word_t i_ex_imm,
  input barrel_pkg::reg_addr_t i_ex_rd,
  input logic i_ex_rd_we,
  input logic i_ex_is_branch,
  input logic i_ex_is_jump,
  input barrel_pkg::funct3_t i_ex_funct3,
  output logic o_wb_valid,
  output barrel_pkg::reg_addr_t o_wb_rd,
  output logic o_wb_rd_we,
  output barrel_pkg::word_t o_wb_data,
  output barrel_pkg::word_t o_wb_next_pc
);

  import barrel_pkg::*;

  logic lt_s;
  logic lt_u;
  logic eq;
  logic [4:0] shamt;
  word_t alu_res;
  logic take;
  word_t pc_plus4;
  word_t target;

  // comparisons shared by slt and the branches
  assign lt_s = $signed(i_ex_op1) < $signed(i_ex_op2);
  assign lt_u = i_ex_op1 < i_ex_op2;
  assign eq = (i_ex_op1 == i_ex_op2);
  assign shamt = i_ex_op2[4:0];

  // ------------------------------------------------------------------------
  // alu
  // ------------------------------------------------------------------------
  always_comb begin
    case (i_ex_alu_op)
      ALU_ADD: alu_res = i_ex_op1 + i_ex_op2;
      ALU_SUB: alu_res = i_ex_op1 - i_ex_op2;
      ALU_SLL: alu_res = i_ex_op1 << shamt;
      ALU_SLT: alu_res = word_t'(lt_s);
      ALU_SLTU: alu_res = word_t'(lt_u);
      ALU_XOR: alu_res = i_ex_op1 ^ i_ex_op2;
      ALU_SRL: alu_res = i_ex_op1 >> shamt;
      ALU_SRA: alu_res = word_t'($signed(i_ex_op1) >>> shamt);
      ALU_OR: alu_res = i_ex_op1 | i_ex_op2;
      ALU_AND: alu_res = i_ex_op1 & i_ex_op2;
      default: alu_res = '0;
    endcase
  end

  // ------------------------------------------------------------------------
  // branch and next pc
  // ------------------------------------------------------------------------
  always_comb begin
    case (i_ex_funct3)
      F3_BEQ: take = eq;
      F3_BNE: take = !eq;
      F3_BLT: take = lt_s;
      F3_BGE: take = !lt_s;
      F3_BLTU: take = lt_u;
      F3_BGEU: take = !lt_u;
      default: take = 1'b0;
    endcase
  end

  assign pc_plus4 = i_ex_pc + 32'd4;
  assign target = i_ex_pc + i_ex_imm;

  // execute/writeback register
  always_ff @(posedge clk) begin
    if (reset) begin
      o_wb_valid <= 1'b0;
    end else begin
      o_wb_valid <= i_ex_valid;
    end
    o_wb_rd <= i_ex_rd;
    o_wb_rd_we <= i_ex_rd_we;
    // jal links pc+4
    o_wb_data <= i_ex_is_jump ? pc_plus4 : alu_res;
    o_wb_next_pc <= (i_ex_is_jump || (i_ex_is_branch && take)) ? target : pc_plus4;
  end

  // immediates from decode must keep the pc on a word
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    o_wb_valid |-> o_wb_next_pc[1:0] == 2'b00);

endmodule

// File: hdl/barrel_core.sv
`timescale 1ns/100ps

module barrel_core #(
  parameter int NUM_THREADS = 4
) (
  input logic clk,
  input logic reset,
  input barrel_pkg::word_t i_rom_instruction,
  output barrel_pkg::rom_addr_t o_rom_addr,
  output logic o_wb_en,
  output logic [$clog2(NUM_THREADS)-1:0] o_wb_thread,
  output barrel_pkg::reg_addr_t o_wb_addr,
  output barrel_pkg::word_t o_wb_data
);

  import barrel_pkg::*;

  localparam int TW = $clog2(NUM_THREADS);

  // fewer threads than stages would need forwarding
  if (NUM_THREADS < MIN_THREADS) begin : g_check
    $error("NUM_THREADS must be at least MIN_THREADS");
  end

  logic [TW-1:0] fetch_thread;
  logic [TW-1:0] decode_thread;
  logic fetch_valid;
  word_t fetch_pc;
  reg_addr_t rs1, rs2;
  word_t rs1_data, rs2_data;

  // decode to execute
  logic ex_valid;
  alu_op_e ex_alu_op;
  word_t ex_op1, ex_op2, ex_pc, ex_imm;
  reg_addr_t ex_rd;
  logic ex_rd_we, ex_is_branch, ex_is_jump;
  funct3_t ex_funct3;

  // execute to writeback
  logic wb_valid;
  reg_addr_t wb_rd;
  logic wb_rd_we;
  word_t wb_data, wb_next_pc;

  ctx_write_if #(.NUM_THREADS(NUM_THREADS)) wr_if ();
  ctx_read_if rd_if [NUM_THREADS] ();

  thread_scheduler #(.NUM_THREADS(NUM_THREADS)) u_sched (
    .clk(clk), .reset(reset),
    .i_wb_valid(wb_valid), .i_wb_rd(wb_rd), .i_wb_rd_we(wb_rd_we),
    .i_wb_data(wb_data), .i_wb_next_pc(wb_next_pc),
    .o_fetch_thread(fetch_thread), .o_decode_thread(decode_thread),
    .o_fetch_valid(fetch_valid), .o_wb_thread(o_wb_thread),
    .wr(wr_if.sched)
  );

  for (genvar g = 0; g < NUM_THREADS; g++) begin : g_ctx
    thread_context #(.NUM_THREADS(NUM_THREADS), .THREAD_ID(g)) u_ctx (
      .clk(clk), .reset(reset), .i_rs1(rs1), .i_rs2(rs2),
      .wr(wr_if.ctx), .rd(rd_if[g].ctx)
    );
  end

  context_select #(.NUM_THREADS(NUM_THREADS)) u_sel (
    .i_fetch_thread(fetch_thread), .i_decode_thread(decode_thread), .rd(rd_if),
    .o_fetch_pc(fetch_pc), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  decode_unit u_dec (
    .clk(clk), .reset(reset), .i_instruction(i_rom_instruction), .i_valid(fetch_valid),
    .i_fetch_pc(fetch_pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_rs1(rs1), .o_rs2(rs2), .o_ex_valid(ex_valid), .o_ex_alu_op(ex_alu_op),
    .o_ex_op1(ex_op1), .o_ex_op2(ex_op2), .o_ex_pc(ex_pc), .o_ex_imm(ex_imm),
    .o_ex_rd(ex_rd), .o_ex_rd_we(ex_rd_we), .o_ex_is_branch(ex_is_branch),
    .o_ex_is_jump(ex_is_jump), .o_ex_funct3(ex_funct3)
  );

  execute_unit u_exe (
    .clk(clk), .reset(reset), .i_ex_valid(ex_valid), .i_ex_alu_op(ex_alu_op),
    .i_ex_op1(ex_op1), .i_ex_op2(ex_op2), .i_ex_pc(ex_pc), .i_ex_imm(ex_imm),
    .i_ex_rd(ex_rd), .i_ex_rd_we(ex_rd_we), .i_ex_is_branch(ex_is_branch),
    .i_ex_is_jump(ex_is_jump), .i_ex_funct3(ex_funct3),
    .o_wb_valid(wb_valid), .o_wb_rd(wb_rd), .o_wb_rd_we(wb_rd_we),
    .o_wb_data(wb_data), .o_wb_next_pc(wb_next_pc)
  );

  assign o_rom_addr = fetch_pc[11:2];

  // debug port mirrors the register write
  assign o_wb_en = wr_if.rd_we;
  assign o_wb_addr = wr_if.rd;
  assign o_wb_data = wr_if.data;

endmodule

// File: verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// program words, byte address 0x00 upwards
localparam int PROG_LEN = 39;
localparam logic [31:0] PROG [PROG_LEN] = '{
  32'h00300093, 32'h06450113, 32'h123451B7, 32'h6781E213, 32'h0F027293, 32'hFFF2C313,
  32'h00032393, 32'h1002B413, 32'h00451493, 32'h00435593, 32'h40435613, 32'h009106B3,
  32'h40A48733, 32'h006277B3, 32'h0072E833, 32'h003248B3, 32'h00139933, 32'h001359B3,
  32'h40135A33, 32'h00532AB3, 32'h00533B33, 32'h00008463, 32'h00035463, 32'h00AB8BB3,
  32'hFFF08093, 32'hFE009CE3, 32'h00534463, 32'h00100C13, 32'h0062E463, 32'h00200C13,
  32'h00537463, 32'h00300C13, 32'h00800CEF, 32'h00400C13, 32'h01539463, 32'h01538463,
  32'h00500C13, 32'h40AB8D33, 32'h0000006F
};

// byte pc of each fetch, the last entry repeats forever (jal x0 to itself)
localparam int FT_LEN = 40;
localparam logic [31:0] FETCH_TRACE [FT_LEN] = '{
  32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h1C, 32'h20, 32'h24,
  32'h28, 32'h2C, 32'h30, 32'h34, 32'h38, 32'h3C, 32'h40, 32'h44, 32'h48, 32'h4C,
  32'h50, 32'h54, 32'h58, 32'h5C, 32'h60, 32'h64, 32'h5C, 32'h60, 32'h64, 32'h5C,
  32'h60, 32'h64, 32'h68, 32'h70, 32'h78, 32'h80, 32'h88, 32'h8C, 32'h94, 32'h98
};

// writebacks: register, constant, multiplier of the hart number
localparam int WB_LEN = 29;
localparam logic [4:0] WB_RD [WB_LEN] = '{
  5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15,
  5'd16, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23, 5'd1, 5'd23, 5'd1, 5'd23, 5'd1,
  5'd25, 5'd26
};
localparam logic [31:0] WB_CONST [WB_LEN] = '{
  32'd3, 32'd100, 32'h12345000, 32'h12345678, 32'h70, 32'hFFFFFF8F, 32'd1, 32'd1, 32'd0,
  32'h0FFFFFF8, 32'hFFFFFFF8, 32'd100, 32'd0, 32'h12345608, 32'h71, 32'h678, 32'd8,
  32'h1FFFFFF1, 32'hFFFFFFF1, 32'd1, 32'd0, 32'd0, 32'd2, 32'd0, 32'd1, 32'd0, 32'd0,
  32'h84, 32'd0
};
localparam int WB_MULT [WB_LEN] = '{
  0, 1, 0, 0, 0, 0, 0, 0, 16, 0, 0, 17, 15, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 2, 0, 3, 0, 0, 2
};

`endif

// File: verif/tb_barrel_core.sv
`timescale 1ns/100ps

module tb_barrel_core;

  import barrel_pkg::*;

  localparam int NUM_THREADS = 4;
  // enough fetches per thread to reach the halt loop
  localparam int FETCHES_PER_THREAD = 50;
  localparam int TIMEOUT_CYCLES = 2000;

  `include "tb_program.svh"

  logic clk;
  logic reset;
  word_t rom_instruction;
  rom_addr_t rom_addr;
  logic wb_en;
  logic [1:0] wb_thread;
  reg_addr_t wb_addr;
  word_t wb_data;

  logic running;
  int edge_n;
  int fetch_total;
  int wb_slots;
  int errors;
  int fetch_count [NUM_THREADS];
  int wb_count [NUM_THREADS];

  barrel_core #(.NUM_THREADS(NUM_THREADS)) dut0 (
    .clk(clk),
    .reset(reset),
    .i_rom_instruction(rom_instruction),
    .o_rom_addr(rom_addr),
    .o_wb_en(wb_en),
    .o_wb_thread(wb_thread),
    .o_wb_addr(wb_addr),
    .o_wb_data(wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // rom model, one cycle read
  // ------------------------------------------------------------------------
  function automatic word_t rom_word(input rom_addr_t a);
    if (int'(a) < PROG_LEN) begin
      return PROG[a];
    end
    // nop outside the program
    return 32'h00000013;
  endfunction

  always @(posedge clk) begin
    rom_instruction <= rom_word(rom_addr);
  end

  // ------------------------------------------------------------------------
  // monitor and checks
  // ------------------------------------------------------------------------
  // at the k-th edge after reset release, fetch k-3 and writeback slot k-6
  always @(posedge clk) begin
    int n;
    int t;
    int idx;
    word_t exp_pc;
    word_t exp_data;
    if (reset) begin
      assert (!wb_en) else begin
        errors++;
        $display("writeback enable went high during reset");
      end
    end else if (running) begin
      edge_n++;
      if (edge_n < 6) begin
        assert (!wb_en) else begin
          errors++;
          $display("writeback enable high before the first instruction reached writeback");
        end
      end
      if (edge_n >= 3) begin
        n = edge_n - 3;
        t = n % NUM_THREADS;
        idx = fetch_count[t];
        exp_pc = (idx < FT_LEN) ? FETCH_TRACE[idx] : FETCH_TRACE[FT_LEN-1];
        assert (rom_addr == exp_pc[11:2]) else begin
          errors++;
          $display("Error fetch t%0d #%0d: expected %h, actual %h",
                   t, idx, exp_pc[11:2], rom_addr);
        end
        fetch_count[t]++;
        fetch_total++;
      end
      if (edge_n >= 6) begin
        n = edge_n - 6;
        t = n % NUM_THREADS;
        assert (wb_thread == 2'(t)) else begin
          errors++;
          $display("Error wb_thread slot %0d: expected %0d, actual %0d", n, t, wb_thread);
        end
        if (wb_en) begin
          assert (wb_addr != 5'd0) else begin
            errors++;
            $display("writeback to x0 reported on the debug port");
          end
          idx = wb_count[t];
          if (idx >= WB_LEN) begin
            errors++;
            $display("thread %0d wrote more registers than the program does", t);
          end else begin
            exp_data = WB_CONST[idx] + word_t'(WB_MULT[idx] * t);
            assert (wb_addr == WB_RD[idx]) else begin
              errors++;
              $display("Error wb_addr t%0d #%0d: expected %0d, actual %0d",
                       t, idx, WB_RD[idx], wb_addr);
            end
            assert (wb_data == exp_data) else begin
              errors++;
              $display("Error wb_data t%0d #%0d: expected %h, actual %h",
                       t, idx, exp_data, wb_data);
            end
          end
          wb_count[t]++;
        end
        wb_slots++;
      end
    end
  end

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    bit done;
    reset = 1'b1;
    rom_instruction = '0;
    running = 1'b0;
    edge_n = 0;
    fetch_total = 0;
    wb_slots = 0;
    errors = 0;
    for (int i = 0; i < NUM_THREADS; i++) begin
      fetch_count[i] = 0;
      wb_count[i] = 0;
    end

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    running <= 1'b1;

    // all fetches
    done = 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
      @(posedge clk);
      if (fetch_total >= FETCHES_PER_THREAD * NUM_THREADS) begin
        done = 1'b1;
        break;
      end
    end
    if (!done) begin
      $display("timeout waiting for the fetch stream");
      $display("Simulation FAILED");
      $finish;
    end else begin
      // drain the pipeline
      done = 1'b0;
      for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
        @(posedge clk);
        if (wb_slots >= FETCHES_PER_THREAD * NUM_THREADS) begin
          done = 1'b1;
          break;
        end
      end
      if (!done) begin
        $display("timeout waiting for the last writebacks");
        $display("Simulation FAILED");
        $finish;
      end else begin
        for (int i = 0; i < NUM_THREADS; i++) begin
          assert (wb_count[i] == WB_LEN) else begin
            errors++;
            $display("Error wb_count t%0d: expected %0d, actual %0d", i, WB_LEN, wb_count[i]);
          end
        end
        $display("errors: %0d, fetches: %0d, writeback slots: %0d",
                 errors, fetch_total, wb_slots);
        if (errors == 0) begin
          $display("Simulation PASSED");
        end else begin
          $display("Simulation FAILED");
        end
        $finish;
      end
    end
  end

endmodule

// File: list.f
+incdir+verif
hdl/barrel_pkg.sv
hdl/barrel_ifs.sv
hdl/thread_scheduler.sv
hdl/thread_context.sv
hdl/context_select.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/barrel_core.sv
verif/tb_barrel_core.sv

// File: run.sh
#!/bin/sh
# build and run the barrel core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_barrel_core -f list.f -o tb_barrel_core

./obj_dir/tb_barrel_core > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: no result line in sim.log"
  exit 1
fi
exit 0
